//--- bench/ibufCases.txt
# Columns: test flush stall stallFetch decodeReady lane0 lane1 lane2 lane3
# A line holding only "end" closes the current test
1 0 0 0 0 0 0 0 0
1 0 0 0 1 0 0 0 0
1 0 0 0 0 1 1 1 1
end
2 0 0 0 1 1 0 1 0
2 0 0 0 1 0 0 0 1
2 0 0 0 1 0 1 1 1
2 0 0 0 1 1 1 1 1
2 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0
end
3 0 1 0 1 1 1 1 1
3 0 1 0 1 1 1 1 1
3 0 1 0 1 1 1 1 1
3 0 1 0 1 0 0 1 0
3 0 1 0 1 1 1 1 1
3 0 1 0 1 0 1 0 1
3 0 0 0 1 1 1 1 1
3 0 0 0 1 1 0 0 1
3 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0
3 0 0 0 1 0 0 1 0
3 0 0 0 0 0 0 0 0
end
4 0 1 0 1 1 1 1 0
4 0 1 0 0 0 0 0 0
4 0 1 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0
4 0 1 0 1 0 1 0 0
4 0 0 0 0 0 0 0 0
end
5 0 0 1 1 1 1 1 1
5 0 0 0 0 1 1 1 1
5 0 0 0 1 1 0 0 1
5 0 0 1 1 1 1 0 0
5 0 0 0 0 0 0 0 0
end
6 0 1 0 1 1 1 1 1
6 0 1 0 1 1 1 1 0
6 1 0 0 1 1 1 1 1
6 0 0 0 1 1 0 0 1
6 0 0 0 1 0 1 1 0
6 0 0 0 0 0 0 0 0
end

//--- all.f
design/ibufParamsPkg.sv
design/ibufTypesPkg.sv
design/ibufWrIf.sv
design/ibufWriteLanes.sv
design/ibufControl.sv
design/ibufRam.sv
design/ibufTop.sv
bench/ibufChecker.sv
bench/ibufTb.sv

//--- Makefile
TOP := ibufTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TOP) -Mdir obj_dir -f all.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

//--- bench/ibufTb.sv
module ibufTb
  import ibufParamsPkg::*;
  import ibufTypesPkg::*;
  ();

  timeunit 1ns;
  timeprecision 100ps;

  // Starting state of the instruction word generator
  localparam logic [31:0] Seed = 32'h95a37bfc;
  // Cycles any single wait may take
  localparam int WaitLimit = 20;

  logic     clk;
  logic     reset;
  logic     flush;
  logic     stall;
  logic     stallFetch;
  logic     decodeReady;
  ibufPkt_t ibPacket [WriteLanes];
  logic     full;
  logic     ready;
  ibufPkt_t renPacket [DispatchWidth];

  // Handshake with the checker
  int   testNum;
  logic testEnd;
  logic resetSeen;
  logic testAck;
  int   testsRun;
  int   testsFailed;
  int   errorCount;

  // Running pc, unique per offered packet
  logic [31:0] seqNum;
  logic [31:0] randState;
  // Set when the run cannot go on
  logic        aborted;

  // Period of 4 ns
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ibufTop dut_i (
    .clk           (clk),
    .reset         (reset),
    .flush_i       (flush),
    .stall_i       (stall),
    .stallFetch_i  (stallFetch),
    .decodeReady_i (decodeReady),
    .ibPacket_i    (ibPacket),
    .full_o        (full),
    .ready_o       (ready),
    .renPacket_o   (renPacket)
  );

  ibufChecker portCheck (
    .clk           (clk),
    .reset         (reset),
    .flush_i       (flush),
    .stall_i       (stall),
    .stallFetch_i  (stallFetch),
    .decodeReady_i (decodeReady),
    .ibPacket_i    (ibPacket),
    .full_i        (full),
    .ready_i       (ready),
    .renPacket_i   (renPacket),
    .testNum_i     (testNum),
    .testEnd_i     (testEnd),
    .resetSeen_o   (resetSeen),
    .testAck_o     (testAck),
    .testsRun_o    (testsRun),
    .testsFailed_o (testsFailed),
    .errors_o      (errorCount)
  );

  // Xorshift32 step
  function automatic logic [31:0] nextRandom(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Control inputs plus fresh packets on every lane, valid or not
  task automatic driveInputs(input logic fl, input logic st, input logic sf,
                             input logic dr, input logic [WriteLanes-1:0] lanes);
    flush       = fl;
    stall       = st;
    stallFetch  = sf;
    decodeReady = dr;
    for (int lane = 0; lane < WriteLanes; lane++)
    begin
      ibPacket[lane].valid = lanes[lane];
      ibPacket[lane].pc    = seqNum;
      ibPacket[lane].instr = randState;
      seqNum    = seqNum + 32'd1;
      randState = nextRandom(randState);
    end
  endtask

  initial
  begin
    int    fd;
    string line;
    int    fields;
    int    tNum;
    int    fl;
    int    st;
    int    sf;
    int    dr;
    int    v0;
    int    v1;
    int    v2;
    int    v3;
    int    waitCycles;

    reset     = 1'b1;
    testNum   = 0;
    testEnd   = 1'b0;
    aborted   = 1'b0;
    seqNum    = 32'd0;
    randState = Seed;
    fd        = 0;
    driveInputs(1'b0, 1'b0, 1'b0, 1'b0, '0);

    // Reset held for 4 cycles, released on a falling edge
    repeat (4) @(negedge clk);
    reset = 1'b0;

    waitCycles = 0;
    while (!resetSeen && waitCycles < WaitLimit)
    begin
      @(negedge clk);
      waitCycles++;
    end
    if (!resetSeen)
    begin
      $display("timeout: checker never saw reset go low");
      aborted = 1'b1;
    end

    if (!aborted)
    begin
      fd = $fopen("bench/ibufCases.txt", "r");
      if (fd == 0)
      begin
        $display("cannot open bench/ibufCases.txt for reading");
        aborted = 1'b1;
      end
    end

    // One data line per cycle, comment and blank lines skipped
    while (!aborted && !$feof(fd))
    begin
      void'($fgets(line, fd));
      fields = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                       tNum, fl, st, sf, dr, v0, v1, v2, v3);
      if (fields == 9)
      begin
        testNum = tNum;
        driveInputs(fl != 0, st != 0, sf != 0, dr != 0,
                    {v3 != 0, v2 != 0, v1 != 0, v0 != 0});
        @(negedge clk);
      end
      else if (line.len() > 0 && line.getc(0) == "e")
      begin
        // Stalled and idle while the checker closes the test
        driveInputs(1'b0, 1'b1, 1'b0, 1'b0, '0);
        testEnd    = 1'b1;
        waitCycles = 0;
        while (!testAck && waitCycles < WaitLimit)
        begin
          @(negedge clk);
          waitCycles++;
        end
        if (!testAck)
        begin
          $display("timeout: checker did not close test %0d", testNum);
          aborted = 1'b1;
        end
        testEnd = 1'b0;
      end
    end
    if (fd != 0)
    begin
      $fclose(fd);
    end

    $display("%0d tests run, %0d failing, %0d mismatches", testsRun, testsFailed, errorCount);
    if (aborted || testsFailed != 0 || errorCount != 0)
    begin
      $display("tests failed");
    end
    else
    begin
      $display("all tests passed");
    end
    $finish;
  end

endmodule

//--- bench/ibufChecker.sv
module ibufChecker
  import ibufParamsPkg::*;
  import ibufTypesPkg::*;
  (
    input  logic     clk,
    input  logic     reset,
    // DUT inputs, as driven by the testbench
    input  logic     flush_i,
    input  logic     stall_i,
    input  logic     stallFetch_i,
    input  logic     decodeReady_i,
    input  ibufPkt_t ibPacket_i [WriteLanes],
    // DUT outputs under check
    input  logic     full_i,
    input  logic     ready_i,
    input  ibufPkt_t renPacket_i [DispatchWidth],
    // Test bookkeeping from the testbench
    input  int       testNum_i,
    input  logic     testEnd_i,
    output logic     resetSeen_o,
    output logic     testAck_o,
    output int       testsRun_o,
    output int       testsFailed_o,
    output int       errors_o
  );

  timeunit 1ns;
  timeprecision 100ps;

  // Wide enough for a whole packet, smaller values are zero extended
  typedef logic [PktWidth-1:0] word_t;

  // Accepted packets, oldest first
  ibufPkt_t model [$];
  // Occupancy as the model sees it
  int modelCount;
  // Mismatches and checks of the running test
  int testErrors;
  int testChecks;

  // One comparison, logged right away on mismatch
  task automatic compare(input string name, input word_t expected, input word_t actual);
    testChecks++;
    if (actual !== expected)
    begin
      testErrors++;
      errors_o++;
      $display("ERR %s expected 0x%0h got 0x%0h in test %0d at %0t",
               name, expected, actual, testNum_i, $time);
    end
  endtask

  // Everything is sampled at the rising edge
  // Inputs change on the falling edge, so they are settled here
  always @(posedge clk)
  begin
    logic expFull;
    logic expReady;

    if (reset)
    begin
      model.delete();
      modelCount    = 0;
      testErrors    = 0;
      testChecks    = 0;
      testsRun_o    = 0;
      testsFailed_o = 0;
      errors_o      = 0;
      resetSeen_o   = 1'b0;
      testAck_o     = 1'b0;
    end
    else
    begin
      resetSeen_o = 1'b1;

      // Full keeps space for one whole group of WriteLanes packets
      expFull  = modelCount > (QueueDepth - WriteLanes);
      // A bundle only leaves when it is complete and rename is not stalled
      expReady = (modelCount >= DispatchWidth) && !stall_i;

      compare("full_o", word_t'(expFull), word_t'(full_i));
      compare("ready_o", word_t'(expReady), word_t'(ready_i));

      // Bundle content matters only while it is offered
      if (expReady && ready_i)
      begin
        for (int port = 0; port < DispatchWidth; port++)
        begin
          compare($sformatf("renPacket_o[%0d]", port),
                  word_t'(model[port]), word_t'(renPacket_i[port]));
        end
      end

      // Model update for this edge
      if (flush_i)
      begin
        // Flush wins over the write and dispatch of the same edge
        model.delete();
        modelCount = 0;
      end
      else
      begin
        if (expReady)
        begin
          repeat (DispatchWidth) void'(model.pop_front());
          modelCount = modelCount - DispatchWidth;
        end
        // Write gate, then valid lanes go in lane order with no gaps
        if (decodeReady_i && !expFull && !stallFetch_i)
        begin
          for (int lane = 0; lane < WriteLanes; lane++)
          begin
            if (ibPacket_i[lane].valid)
            begin
              model.push_back(ibPacket_i[lane]);
              modelCount++;
            end
          end
        end
      end

      // Test closes after the checks of its last edge
      if (testEnd_i && !testAck_o)
      begin
        testsRun_o++;
        if (testErrors == 0)
        begin
          $display("test %0d passed, %0d checks", testNum_i, testChecks);
        end
        else
        begin
          testsFailed_o++;
          $display("test %0d FAILED, %0d of %0d checks wrong",
                   testNum_i, testErrors, testChecks);
        end
        testErrors = 0;
        testChecks = 0;
        testAck_o  = 1'b1;
      end
      else if (!testEnd_i)
      begin
        testAck_o = 1'b0;
      end
    end
  end

endmodule

//--- design/ibufTop.sv
module ibufTop
  import ibufParamsPkg::*;
  import ibufTypesPkg::*;
  (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush_i,
    input  logic     stall_i,
    input  logic     stallFetch_i,
    input  logic     decodeReady_i,
    // Up to WriteLanes packets from decode
    input  ibufPkt_t ibPacket_i [WriteLanes],
    output logic     full_o,
    output logic     ready_o,
    // Bundle for rename, valid while ready_o is high
    output ibufPkt_t renPacket_o [DispatchWidth]
  );

  // Write traffic between lanes, control and storage
  ibufWrIf wrBus ();

  // Valid bits pulled out of the incoming packets
  logic [WriteLanes-1:0] laneValid;

  // Read addresses from control to storage
  ibufIdx_t rdAddr [DispatchWidth];

  for (genvar lane = 0; lane < WriteLanes; lane++)
  begin : gLaneValid
    assign laneValid[lane] = ibPacket_i[lane].valid;
  end

  // Compaction of valid lanes
  ibufWriteLanes writeLanes (
    .wr_i        (wrBus.lanes),
    .laneValid_i (laneValid)
  );

  // Pointers, count and handshake
  ibufControl control (
    .clk           (clk),
    .reset         (reset),
    .flush_i       (flush_i),
    .stall_i       (stall_i),
    .stallFetch_i  (stallFetch_i),
    .decodeReady_i (decodeReady_i),
    .wr_o          (wrBus.ctrl),
    .rdAddr_o      (rdAddr),
    .full_o        (full_o),
    .ready_o       (ready_o)
  );

  // Packet storage
  ibufRam ram (
    .clk      (clk),
    .wr_i     (wrBus.ram),
    .wrData_i (ibPacket_i),
    .rdAddr_i (rdAddr),
    .rdData_o (renPacket_o)
  );

endmodule

//--- design/ibufRam.sv
module ibufRam
  import ibufParamsPkg::*;
  import ibufTypesPkg::*;
  (
    input  logic     clk,
    ibufWrIf.ram     wr_i,
    input  ibufPkt_t wrData_i [WriteLanes],
    input  ibufIdx_t rdAddr_i [DispatchWidth],
    output ibufPkt_t rdData_o [DispatchWidth]
  );

  // Flat storage of all queue entries
  logic [PktWidth-1:0] mem [QueueDepth];

  // One write port per lane
  // Compacted addresses are distinct, so ports never collide
  always_ff @(posedge clk)
  begin
    for (int lane = 0; lane < WriteLanes; lane++)
    begin
      if (wr_i.wrEn[lane])
      begin
        mem[wr_i.wrAddr[lane]] <= wrData_i[lane];
      end
    end
  end

  // Asynchronous read ports, one per dispatch slot
  always_comb
  begin
    for (int port = 0; port < DispatchWidth; port++)
    begin
      rdData_o[port] = ibufPkt_t'(mem[rdAddr_i[port]]);
    end
  end

endmodule

//--- design/ibufControl.sv
module ibufControl
  import ibufParamsPkg::*;
  (
    input  logic     clk,
    input  logic     reset,
    // Branch recovery, empties the queue
    input  logic     flush_i,
    // Back end cannot take a bundle
    input  logic     stall_i,
    // Fetch held off by the power manager
    input  logic     stallFetch_i,
    // Decode has a group for us
    input  logic     decodeReady_i,
    ibufWrIf.ctrl    wr_o,
    output ibufIdx_t rdAddr_o [DispatchWidth],
    output logic     full_o,
    output logic     ready_o
  );

  // Oldest entry, first to dispatch
  ibufIdx_t headPtr;
  // Next free entry
  ibufIdx_t tailPtr;
  // Entries currently held
  ibufCnt_t instCount;

  ibufIdx_t headNext;
  ibufIdx_t tailNext;
  ibufCnt_t countNext;

  // Full leaves room for one whole write group
  assign full_o = (instCount > ibufCnt_t'(FullThreshold));

  // Bundles go out all or nothing
  assign ready_o = (instCount >= ibufCnt_t'(DispatchWidth)) & ~stall_i;

  // Every blocking condition is folded into one write gate
  assign wr_o.writeAllow = decodeReady_i & ~full_o & ~stallFetch_i;
  assign wr_o.tailPtr    = tailPtr;

  always_comb
  begin
    // Tail moves by the compacted write count
    tailNext  = tailPtr + ibufIdx_t'(wr_o.writeCount);
    headNext  = headPtr;
    countNext = instCount + ibufCnt_t'(wr_o.writeCount);

    // A dispatch retires one bundle from the head
    if (ready_o)
    begin
      headNext  = headPtr + ibufIdx_t'(DispatchWidth);
      countNext = countNext - ibufCnt_t'(DispatchWidth);
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end
    else if (flush_i)
    begin
      // Same-cycle writes and dispatch are dropped
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end
    else
    begin
      headPtr   <= headNext;
      tailPtr   <= tailNext;
      instCount <= countNext;
    end
  end

  // Consecutive entries from the head, wrapping by overflow
  always_comb
  begin
    for (int port = 0; port < DispatchWidth; port++)
    begin
      rdAddr_o[port] = headPtr + ibufIdx_t'(port);
    end
  end

endmodule

//--- design/ibufWriteLanes.sv
module ibufWriteLanes
  import ibufParamsPkg::*;
  (
    ibufWrIf.lanes             wr_i,
    input logic [WriteLanes-1:0] laneValid_i
  );

  // Lanes are walked in order
  // Each valid lane claims the entry after the previous valid lane
  // Invalid lanes consume no entry, which removes the gaps
  always_comb
  begin
    ibufIdx_t nextAddr;
    laneCnt_t enCount;

    // First valid lane lands on the tail
    nextAddr = wr_i.tailPtr;
    enCount  = '0;

    for (int lane = 0; lane < WriteLanes; lane++)
    begin
      // Address is handed out even for invalid lanes
      // It is harmless because wrEn stays low there
      wr_i.wrAddr[lane] = nextAddr;

      // Write only when control accepts this cycle
      wr_i.wrEn[lane] = laneValid_i[lane] & wr_i.writeAllow;

      // Advance only past lanes that occupy an entry
      if (laneValid_i[lane])
      begin
        nextAddr = nextAddr + ibufIdx_t'(1);
      end

      // Running total of enabled lanes
      enCount = enCount + laneCnt_t'(wr_i.wrEn[lane]);
    end

    // Zero when writes are blocked, so the tail holds
    wr_i.writeCount = enCount;
  end

endmodule

//--- design/ibufWrIf.sv
interface ibufWrIf
  import ibufParamsPkg::*;
  ();

  // Set when the queue takes writes this cycle
  logic     writeAllow;

  // Next free entry of the queue
  ibufIdx_t tailPtr;

  // Per-lane write strobe after compaction
  logic [WriteLanes-1:0] wrEn;

  // Per-lane destination entry
  ibufIdx_t wrAddr [WriteLanes];

  // Number of lanes actually written
  laneCnt_t writeCount;

  // Lane compaction side
  modport lanes (
    input  writeAllow,
    input  tailPtr,
    output wrEn,
    output wrAddr,
    output writeCount
  );

  // Pointer and occupancy side
  modport ctrl (
    output writeAllow,
    output tailPtr,
    input  writeCount
  );

  // Storage write ports
  modport ram (
    input wrEn,
    input wrAddr
  );

endinterface

//--- design/ibufTypesPkg.sv
package ibufTypesPkg;

  // One decoded instruction as it travels from fetch to dispatch
  typedef struct packed {
    // Lane carries a real instruction
    logic        valid;
    // Fetch address of the instruction
    logic [31:0] pc;
    // Raw instruction word
    logic [31:0] instr;
  } ibufPkt_t;

  // Flat width of one packet, used for the storage array
  localparam int PktWidth = $bits(ibufPkt_t);

endpackage

//--- design/ibufParamsPkg.sv
package ibufParamsPkg;

  // Instructions delivered by one fetch group
  localparam int FetchWidth = 2;

  // Decode may split instructions, so twice the fetch width arrives per cycle
  localparam int WriteLanes = 2 * FetchWidth;

  // Packets handed to rename in one bundle
  localparam int DispatchWidth = 2;

  // Queue entries, kept a power of two so pointers wrap on overflow
  localparam int QueueDepth = 16;

  // Index width of one queue entry
  localparam int QueueLog = $clog2(QueueDepth);

  // Above this occupancy a full write group might not fit
  localparam int FullThreshold = QueueDepth - WriteLanes;

  // Width needed to count 0 to WriteLanes packets
  localparam int LaneCntWidth = $clog2(WriteLanes + 1);

  // Entry index into the circular queue
  typedef logic [QueueLog-1:0] ibufIdx_t;

  // Occupancy count
  // One extra bit so a completely full queue is representable
  typedef logic [QueueLog:0] ibufCnt_t;

  // Packets written in a single cycle
  typedef logic [LaneCntWidth-1:0] laneCnt_t;

endpackage
